// ==== build.f ====
+incdir+.
hb_pkg.sv
hb_stream_ctrl.sv
hb_sample_history.sv
hb_pair_preadd.sv
hb_coef_mac.sv
hb_round_sat.sv
hb_filter_top.sv
hb_filter_tb.sv

// ==== hb_coef_mac.sv ====
`timescale 1ns/10ps
`include "hb_params.svh"

module hb_coef_mac (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  hb_pkg::stage_en_t stage_en_i,
    input  hb_pkg::pair_bus_t pairs_i,
    output hb_pkg::acc_vec_t  acc_o
);

    // Wider than the accumulator so the bound check can see an overflow
    typedef logic signed [`HB_ACC_W+3:0] wide_t;

    // Accumulator range
    localparam wide_t ACC_MAX = (wide_t'(1) <<< (`HB_ACC_W - 1)) - wide_t'(1);
    localparam wide_t ACC_MIN = -(wide_t'(1) <<< (`HB_ACC_W - 1));

    wide_t [`HB_LANES-1:0] sum_d;
    hb_pkg::acc_vec_t      acc_q;

    ////////////////////////////////
    // Multiply and sum per lane
    ////////////////////////////////

    always_comb begin
        for (int j = 0; j < `HB_LANES; j++) begin
            // Centre tap first
            sum_d[j] = wide_t'(pairs_i[j].centre) * wide_t'(hb_pkg::HB_CENTRE);
            // Then the eight symmetric pairs, odd offsets 1 to 15
            for (int p = 0; p < `HB_NPAIRS; p++) begin
                sum_d[j] = sum_d[j] +
                           wide_t'(pairs_i[j].pair[p]) * wide_t'(hb_pkg::HB_COEFS[p]);
            end
        end
    end

    ////////////////////////////////
    // Accumulator register
    ////////////////////////////////

    // Q15 sums, one edge after the pair sums
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else if (stage_en_i.mac_en) begin
            for (int j = 0; j < `HB_LANES; j++) begin
                acc_q[j] <= hb_pkg::acc_t'(sum_d[j]);
            end
        end
    end

    assign acc_o = acc_q;

    // Pair sums from the pre-add never push a lane past the accumulator range
    for (genvar j = 0; j < `HB_LANES; j++) begin : g_bound
        a_acc_bound : assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            stage_en_i.mac_en |-> (sum_d[j] <= ACC_MAX && sum_d[j] >= ACC_MIN)
        );
    end

endmodule

// ==== hb_filter_tb.sv ====
`timescale 1ns/10ps
`include "hb_params.svh"

module hb_filter_tb;

    localparam int MAX_RECS    = 256;
    localparam int RST_CYCLES  = 5;
    localparam int DRAIN_LIMIT = 20;
    localparam int CENTRE      = 16384;

    logic                clk_i;
    logic                rst_n_i;
    logic                in_valid_i;
    hb_pkg::sample_vec_t in_data_i;
    logic                out_valid_o;
    hb_pkg::out_vec_t    out_data_o;

    // Q15 pair coefficients for offsets 1, 3, ... 15
    int coef_tab [8] = '{10342, -3216, 1672, -949, 263, -526, 105, -23};

    // Records from the data file
    byte                 rec_kind  [MAX_RECS];
    bit                  rec_valid [MAX_RECS];
    hb_pkg::sample_vec_t rec_data  [MAX_RECS];
    int                  rec_count;

    // Reference window with index 0 the oldest and the newest vector in 32 to 39
    int win [40];

    // Predicted vectors in flight and the record each came from
    hb_pkg::out_vec_t exp_q [$];
    int               idx_q [$];

    // Results of the gap-free pass kept per record
    hb_pkg::out_vec_t first_out  [MAX_RECS];
    bit               first_seen [MAX_RECS];

    int         pass_no;
    int         error_count = 0;
    int         seed = 32'h3424018f;
    // Accepted flags on their way to the output
    logic [2:0] vpipe = '0;

    hb_filter_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o)
    );

    initial clk_i = 1'b0;
    always #50 clk_i = ~clk_i;

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic abort_run(input string why);
        error_count++;
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_out(input hb_pkg::out_vec_t got, input hb_pkg::out_vec_t want,
                             input string what);
        for (int j = 0; j < `HB_LANES; j++) begin
            if (got[j] !== want[j]) begin
                abort_run($sformatf("MISMATCH at %0t ns: %s lane %0d got %0d expected %0d",
                                    $time, what, j, got[j], want[j]));
            end
        end
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("MISMATCH at %0t ns: out_valid_o got %b expected %b",
                                $time, got, want));
        end
    endtask

    //////////////////////////////
    // Reference filter
    //////////////////////////////

    // Takes one vector in and predicts its eight outputs
    task automatic model_accept(input hb_pkg::sample_vec_t v, output hb_pkg::out_vec_t y);
        longint acc;
        int     c;
        for (int i = 0; i < 32; i++) begin
            win[i] = win[i+8];
        end
        for (int j = 0; j < `HB_LANES; j++) begin
            win[32+j] = v[j];
        end
        for (int j = 0; j < `HB_LANES; j++) begin
            // Centre tap 15 samples behind output sample m
            c = 32 + j - 15;
            acc = longint'(CENTRE) * win[c];
            for (int p = 0; p < 8; p++) begin
                acc += longint'(coef_tab[p]) * (win[c - (2*p + 1)] + win[c + (2*p + 1)]);
            end
            // Round half-up then drop the fraction
            acc = (acc + 16384) >>> 15;
            if (acc > 2047) begin
                acc = 2047;
            end else if (acc < -2048) begin
                acc = -2048;
            end
            y[j] = hb_pkg::out_samp_t'(acc);
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic load_tests();
        int    fd;
        int    n;
        int    vflag;
        int    h [8];
        byte   kind;
        string line;
        fd = $fopen("hb_tests.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the data file hb_tests.txt");
        end
        rec_count = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comments and blank lines
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%c %d %h %h %h %h %h %h %h %h", kind, vflag,
                            h[0], h[1], h[2], h[3], h[4], h[5], h[6], h[7]);
                if (n != 10 || !(kind == "S" || kind == "E" || kind == "R")) begin
                    abort_run($sformatf("bad line in data file: %s", line));
                end
                if (rec_count >= MAX_RECS) begin
                    abort_run("data file holds too many records");
                end
                rec_kind[rec_count]  = kind;
                rec_valid[rec_count] = vflag[0];
                for (int j = 0; j < `HB_LANES; j++) begin
                    rec_data[rec_count][j] = hb_pkg::sample_t'(h[j]);
                end
                rec_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        for (int i = 0; i < RST_CYCLES; i++) begin
            @(posedge clk_i);
            rst_n_i    <= 1'b0;
            in_valid_i <= 1'b0;
        end
        @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Samples before reset count as zero
        for (int i = 0; i < 40; i++) begin
            win[i] = 0;
        end
    endtask

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            in_valid_i <= 1'b0;
        end
    endtask

    task automatic drive_stimulus(input int idx);
        hb_pkg::out_vec_t y;
        hb_pkg::out_vec_t file_y;
        @(posedge clk_i);
        in_valid_i <= rec_valid[idx];
        in_data_i  <= rec_data[idx];
        if (rec_valid[idx]) begin
            model_accept(rec_data[idx], y);
            exp_q.push_back(y);
            idx_q.push_back(idx);
            // An E line right after holds the hand-derived result
            if (idx + 1 < rec_count && rec_kind[idx+1] == "E") begin
                file_y = rec_data[idx+1];
                check_out(y, file_y, "model vs data file");
            end
        end
    endtask

    // Stops driving and waits until every accepted vector has come out
    task automatic drain_outputs();
        int wait_cycles;
        drive_idle(1);
        wait_cycles = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
            wait_cycles++;
            if (wait_cycles > DRAIN_LIMIT) begin
                abort_run("timeout: out_valid_o did not deliver all accepted vectors");
            end
        end
    endtask

    task automatic run_pass(input bit with_gaps);
        apply_reset();
        for (int i = 0; i < rec_count; i++) begin
            if (rec_kind[i] == "R") begin
                // Results listed in the file leave the DUT before the reset
                // Any other reset lands on vectors still in flight
                if (i > 0 && rec_kind[i-1] == "E") begin
                    drain_outputs();
                end
                apply_reset();
                @(negedge clk_i);
                check_valid(out_valid_o, 1'b0);
            end else if (rec_kind[i] == "S") begin
                if (with_gaps) begin
                    drive_idle($unsigned($random(seed)) % 4);
                end
                drive_stimulus(i);
            end
        end
        drain_outputs();
    endtask

    //////////////////////////////
    // Output monitor
    //////////////////////////////

    // Outputs are stable at the falling edge
    always @(negedge clk_i) begin : monitor_output
        hb_pkg::out_vec_t want;
        int               idx;
        check_valid(out_valid_o, vpipe[2]);
        if (vpipe[2]) begin
            if (exp_q.size() == 0) begin
                abort_run("output marked valid while no accepted vector was pending");
            end
            want = exp_q.pop_front();
            idx  = idx_q.pop_front();
            check_out(out_data_o, want, "DUT vs model");
            if (pass_no == 0) begin
                first_out[idx]  = out_data_o;
                first_seen[idx] = 1'b1;
            end else if (first_seen[idx]) begin
                check_out(out_data_o, first_out[idx], "gapped pass vs gap-free pass");
            end
        end
        // A reset flushes everything in flight
        if (!rst_n_i) begin
            vpipe = '0;
            exp_q.delete();
            idx_q.delete();
        end else begin
            vpipe = {vpipe[1:0], in_valid_i};
        end
    end

    initial begin
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        pass_no    = 0;
        load_tests();
        // Pass 0 runs back to back and pass 1 with random idle gaps
        for (pass_no = 0; pass_no < 2; pass_no++) begin
            run_pass(pass_no == 1);
        end
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hb_filter_top.sv ====
`timescale 1ns/10ps

module hb_filter_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                in_valid_i,
    input  hb_pkg::sample_vec_t in_data_i,
    output logic                out_valid_o,
    output hb_pkg::out_vec_t    out_data_o
);

    ////////////////////////////////
    // Internal buses
    ////////////////////////////////

    // Enables shared by history and datapath
    hb_pkg::stage_en_t stage_en;

    // 40-sample window, oldest first
    hb_pkg::window_t   window;

    // Registered pair sums and centre samples
    hb_pkg::pair_bus_t pairs;

    // Registered Q15 sums
    hb_pkg::acc_vec_t  acc;

    ////////////////////////////////
    // Control and datapath
    ////////////////////////////////

    hb_stream_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .stage_en_o  (stage_en),
        .out_valid_o (out_valid_o)
    );

    hb_sample_history u_hist (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_en_i (stage_en),
        .in_data_i  (in_data_i),
        .window_o   (window)
    );

    hb_pair_preadd u_preadd (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_en_i (stage_en),
        .window_i   (window),
        .pairs_o    (pairs)
    );

    hb_coef_mac u_mac (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_en_i (stage_en),
        .pairs_i    (pairs),
        .acc_o      (acc)
    );

    hb_round_sat u_rsat (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stage_en_i (stage_en),
        .acc_i      (acc),
        .out_data_o (out_data_o)
    );

endmodule

// ==== hb_pair_preadd.sv ====
`timescale 1ns/10ps
`include "hb_params.svh"

module hb_pair_preadd (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  hb_pkg::stage_en_t stage_en_i,
    input  hb_pkg::window_t   window_i,
    output hb_pkg::pair_bus_t pairs_o
);

    // First live sample in the window
    localparam int ANCHOR0 = `HB_HIST_VECS * `HB_LANES;

    // Centre tap sits this many samples behind the anchor
    localparam int CTR_OFS = 2 * `HB_NPAIRS - 1;

    hb_pkg::pair_bus_t pairs_d;
    hb_pkg::pair_bus_t pairs_q;

    ////////////////////////////////
    // Symmetric pre-add
    ////////////////////////////////

    // Lane j output belongs to the live sample at window index ANCHOR0+j
    // Pair p adds the two samples at offset 2p+1 around the centre
    always_comb begin
        for (int j = 0; j < `HB_LANES; j++) begin
            pairs_d[j].centre = window_i[ANCHOR0 + j - CTR_OFS];
            for (int p = 0; p < `HB_NPAIRS; p++) begin
                // Sign-extend both operands before the add
                pairs_d[j].pair[p] =
                    hb_pkg::pair_t'(window_i[ANCHOR0 + j - CTR_OFS - (2*p + 1)]) +
                    hb_pkg::pair_t'(window_i[ANCHOR0 + j - CTR_OFS + (2*p + 1)]);
            end
        end
    end

    ////////////////////////////////
    // Stage register
    ////////////////////////////////

    // Loads on the same edge that accepts the vector
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pairs_q <= '0;
        end else if (stage_en_i.preadd_en) begin
            pairs_q <= pairs_d;
        end
    end

    assign pairs_o = pairs_q;

endmodule

// ==== hb_params.svh ====
`ifndef HB_PARAMS_SVH
`define HB_PARAMS_SVH

// Input sample width, signed
`define HB_SAMP_W 12

// Samples carried by one input vector
`define HB_LANES 8

// Past vectors kept in the history
`define HB_HIST_VECS 4

// Signed Q15 coefficient width
`define HB_COEF_W 16

// Symmetric tap pairs, odd offsets 1 to 15
`define HB_NPAIRS 8

// Output sample width after saturation
`define HB_OUT_W 12

// Accumulator width, covers the worst-case Q15 sum with margin
`define HB_ACC_W 34

// Fraction bits of the coefficients
`define HB_FRAC 15

// Edges from accepted vector to registered output
`define HB_LATENCY 3

`endif

// ==== hb_pkg.sv ====
`include "hb_params.svh"

package hb_pkg;

    ////////////////////////////////
    // Sample and window types
    ////////////////////////////////

    typedef logic signed [`HB_SAMP_W-1:0] sample_t;
    typedef sample_t [`HB_LANES-1:0] sample_vec_t;

    // Index 0 is the oldest sample of the window
    typedef sample_t [(`HB_HIST_VECS+1)*`HB_LANES-1:0] window_t;

    // Pair sum carries one extra bit for the pre-add
    typedef logic signed [`HB_SAMP_W:0] pair_t;

    typedef struct packed {
        pair_t [`HB_NPAIRS-1:0] pair;
        sample_t                centre;
    } lane_pairs_t;

    typedef lane_pairs_t [`HB_LANES-1:0] pair_bus_t;

    typedef logic signed [`HB_ACC_W-1:0] acc_t;
    typedef acc_t [`HB_LANES-1:0] acc_vec_t;

    typedef logic signed [`HB_OUT_W-1:0] out_samp_t;
    typedef out_samp_t [`HB_LANES-1:0] out_vec_t;

    // Per-stage enables from the control block
    typedef struct packed {
        logic hist_shift;
        logic preadd_en;
        logic mac_en;
        logic out_en;
    } stage_en_t;

    ////////////////////////////////
    // Coefficients, Q15
    ////////////////////////////////

    typedef logic signed [`HB_COEF_W-1:0] coef_t;

    // Entry p belongs to tap offset 2p+1
    localparam coef_t HB_COEFS [`HB_NPAIRS] = '{
        16'sd10342, -16'sd3216, 16'sd1672, -16'sd949,
        16'sd263, -16'sd526, 16'sd105, -16'sd23
    };

    // Centre tap, one half
    localparam coef_t HB_CENTRE = 16'sd16384;

endpackage

// ==== hb_round_sat.sv ====
`timescale 1ns/10ps
`include "hb_params.svh"

module hb_round_sat (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  hb_pkg::stage_en_t stage_en_i,
    input  hb_pkg::acc_vec_t  acc_i,
    output hb_pkg::out_vec_t  out_data_o
);

    // One guard bit for the rounding add
    typedef logic signed [`HB_ACC_W:0] rnd_t;

    localparam rnd_t HALF_LSB = rnd_t'(1) <<< (`HB_FRAC - 1);
    localparam rnd_t OUT_MAX  = rnd_t'((1 <<< (`HB_OUT_W - 1)) - 1);
    localparam rnd_t OUT_MIN  = rnd_t'(-(1 <<< (`HB_OUT_W - 1)));

    rnd_t [`HB_LANES-1:0] rnd_d;
    rnd_t [`HB_LANES-1:0] shr_d;
    hb_pkg::out_vec_t     out_d;
    hb_pkg::out_vec_t     out_q;

    // Round half-up, drop the Q15 fraction, clamp to 12 bits
    always_comb begin
        for (int j = 0; j < `HB_LANES; j++) begin
            rnd_d[j] = rnd_t'(acc_i[j]) + HALF_LSB;
            shr_d[j] = rnd_d[j] >>> `HB_FRAC;
            if (shr_d[j] > OUT_MAX) begin
                out_d[j] = hb_pkg::out_samp_t'(OUT_MAX);
            end else if (shr_d[j] < OUT_MIN) begin
                out_d[j] = hb_pkg::out_samp_t'(OUT_MIN);
            end else begin
                out_d[j] = hb_pkg::out_samp_t'(shr_d[j]);
            end
        end
    end

    // Output register, two edges after the pair sums
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
        end else if (stage_en_i.out_en) begin
            out_q <= out_d;
        end
    end

    assign out_data_o = out_q;

endmodule

// ==== hb_sample_history.sv ====
`timescale 1ns/10ps
`include "hb_params.svh"

module hb_sample_history (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  hb_pkg::stage_en_t   stage_en_i,
    input  hb_pkg::sample_vec_t in_data_i,
    output hb_pkg::window_t     window_o
);

    // Stored vectors, entry 0 is the oldest
    hb_pkg::sample_vec_t [`HB_HIST_VECS-1:0] hist_q;

    ////////////////////////////////
    // History shift register
    ////////////////////////////////

    // Shifts only on an accepted vector
    // Idle cycles leave the stored samples untouched
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // Samples before reset count as zero
            hist_q <= '0;
        end else if (stage_en_i.hist_shift) begin
            for (int v = 0; v < `HB_HIST_VECS - 1; v++) begin
                hist_q[v] <= hist_q[v+1];
            end
            // Newest vector goes to the top entry
            hist_q[`HB_HIST_VECS-1] <= in_data_i;
        end
    end

    ////////////////////////////////
    // Window assembly
    ////////////////////////////////

    // Live input on the high end, oldest stored vector on the low end
    // Window index is 8 * vector + lane
    assign window_o = hb_pkg::window_t'({in_data_i, hist_q});

endmodule

// ==== hb_stream_ctrl.sv ====
`timescale 1ns/10ps
`include "hb_params.svh"

module hb_stream_ctrl (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    output hb_pkg::stage_en_t stage_en_o,
    output logic              out_valid_o
);

    // Valid bit per pipeline stage
    // Bit 0 follows the pair sums, bit 1 the accumulators, bit 2 the output
    logic [`HB_LATENCY-1:0] valid_q;

    ////////////////////////////////
    // Valid pipeline
    ////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[`HB_LATENCY-2:0], in_valid_i};
        end
    end

    ////////////////////////////////
    // Stage enables
    ////////////////////////////////

    // History and pre-add move together with an accepted vector
    assign stage_en_o.hist_shift = in_valid_i;
    assign stage_en_o.preadd_en  = in_valid_i;

    // Later stages load only when the stage before holds valid data
    assign stage_en_o.mac_en     = valid_q[0];
    assign stage_en_o.out_en     = valid_q[1];

    // Output register holds a fresh result
    assign out_valid_o = valid_q[`HB_LATENCY-1];

    // Every accepted vector leaves exactly three edges later
    a_valid_latency : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        in_valid_i |-> ##(`HB_LATENCY) out_valid_o
    );

    // Bubbles stay bubbles at the output
    a_bubble_latency : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !in_valid_i |-> ##(`HB_LATENCY) !out_valid_o
    );

endmodule

// ==== hb_tests.txt ====
# Columns: record type (S stimulus, E expected output of the S above, R reset), valid flag,
# then the eight samples of lanes 0 to 7 in 12-bit hex, lane 0 the oldest
S 1 400 000 000 000 000 000 000 000
E 1 FFF 000 003 000 FF0 000 008 000
S 1 000 000 000 000 000 000 000 000
E 1 FE2 000 034 000 F9C 000 143 200
S 1 000 000 000 000 000 000 000 000
E 1 143 000 F9C 000 034 000 FE2 000
S 1 000 000 000 000 000 000 000 000
E 1 008 000 FF0 000 003 000 FFF 000
R 0 000 000 000 000 000 000 000 000
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
S 0 7FF 7FF 7FF 7FF 7FF 7FF 7FF 7FF
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
E 1 3C8 3C8 3C8 3C8 3C8 3C8 3C8 3C8
R 0 000 000 000 000 000 000 000 000
S 1 7FF 7FF 7FF 801 801 801 801 7FF
S 1 7FF 7FF 7FF 801 801 801 801 7FF
S 1 7FF 7FF 7FF 801 801 801 801 7FF
S 1 7FF 7FF 7FF 801 801 801 801 7FF
S 1 7FF 7FF 7FF 801 801 801 801 7FF
E 1 7FF 400 C01 800 800 C01 400 7FF
S 1 7FF 7FF 7FF 801 801 801 801 7FF
E 1 7FF 400 C01 800 800 C01 400 7FF
R 0 000 000 000 000 000 000 000 000
S 1 801 801 801 7FF 7FF 7FF 7FF 801
S 1 801 801 801 7FF 7FF 7FF 7FF 801
S 1 801 801 801 7FF 7FF 7FF 7FF 801
S 1 801 801 801 7FF 7FF 7FF 7FF 801
S 1 801 801 801 7FF 7FF 7FF 7FF 801
E 1 800 C01 400 7FF 7FF 400 C01 800
R 0 000 000 000 000 000 000 000 000
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
S 1 3E8 3E8 3E8 3E8 3E8 3E8 3E8 3E8
R 0 000 000 000 000 000 000 000 000
S 1 400 000 000 000 000 000 000 000
E 1 FFF 000 003 000 FF0 000 008 000
S 1 000 000 000 000 000 000 000 000
E 1 FE2 000 034 000 F9C 000 143 200
